/* src/lce_pkg.sv */
// lce message type enums, field widths, id typedefs and packed word width functions
package lce_pkg;

  // fixed field widths of the message words
  localparam int req_type_width_c  = 3;
  localparam int resp_type_width_c = 2;
  localparam int cmd_type_width_c  = 3;
  localparam int uc_size_width_c   = 2;
  localparam int lce_id_width_c    = 4;
  localparam int cce_id_width_c    = 4;

  typedef logic [lce_id_width_c-1:0] lce_id_t;
  typedef logic [cce_id_width_c-1:0] cce_id_t;

  // outbound request types
  typedef enum logic [req_type_width_c-1:0] {
    e_req_rd    = 3'd0,
    e_req_wr    = 3'd1,
    e_req_uc_rd = 3'd2,
    e_req_uc_wr = 3'd3
  } req_type_e;

  // outbound response types
  typedef enum logic [resp_type_width_c-1:0] {
    e_resp_coh_ack = 2'd2
  } resp_type_e;

  // inbound command types, codes 4 to 7 are reserved
  typedef enum logic [cmd_type_width_c-1:0] {
    e_cmd_set_tag        = 3'd0,
    e_cmd_set_tag_wakeup = 3'd1,
    e_cmd_data           = 3'd2,
    e_cmd_uc_data        = 3'd3
  } cmd_type_e;

  // uncached access size
  typedef enum logic [uc_size_width_c-1:0] {
    e_uc_byte  = 2'd0,
    e_uc_half  = 2'd1,
    e_uc_word  = 2'd2,
    e_uc_dword = 2'd3
  } uc_size_e;

  // command word is {type, dst lce, addr}
  function automatic int cmd_width_f(int paddr_width);
    return cmd_type_width_c + lce_id_width_c + paddr_width;
  endfunction

  // request word is {type, dst cce, src lce, addr, lru way, dirty, size, data}
  function automatic int req_width_f(int paddr_width, int assoc, int dword_width);
    return req_type_width_c + cce_id_width_c + lce_id_width_c + paddr_width
      + $clog2(assoc) + 1 + uc_size_width_c + dword_width;
  endfunction

  // response word is {type, dst cce, src lce, addr}
  function automatic int resp_width_f(int paddr_width);
    return resp_type_width_c + cce_id_width_c + lce_id_width_c + paddr_width;
  endfunction

endpackage

/* src/lce_cmd_decode.sv */
// cce command decode with target lce filter and registered resolution strobes
`timescale 1ns/10ps

module lce_cmd_decode #(
  parameter int  paddr_width_p = 32,
  localparam int cmd_width_lp  = lce_pkg::cmd_width_f(paddr_width_p)
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  lce_pkg::lce_id_t        lce_id_i,
  input  logic                    cmd_v_i,
  input  logic [cmd_width_lp-1:0] cmd_i,
  output logic                    set_tag_rcv_o,
  output logic                    wakeup_rcv_o,
  output logic                    data_rcv_o,
  output logic                    uc_data_rcv_o
);

  lce_pkg::cmd_type_e cmd_type;
  lce_pkg::lce_id_t   cmd_dst_id;
  logic               cmd_for_me;
  logic               set_tag_n;
  logic               wakeup_n;
  logic               data_n;
  logic               uc_data_n;

  // field split, type on top and dst id just above the address
  assign cmd_type   = lce_pkg::cmd_type_e'(cmd_i[cmd_width_lp-1 -: lce_pkg::cmd_type_width_c]);
  assign cmd_dst_id = cmd_i[paddr_width_p +: lce_pkg::lce_id_width_c];

  // commands for other lces are dropped here
  assign cmd_for_me = cmd_v_i & (cmd_dst_id == lce_id_i);

  always_comb begin
    set_tag_n = 1'b0;
    wakeup_n  = 1'b0;
    data_n    = 1'b0;
    uc_data_n = 1'b0;
    if (cmd_for_me) begin
      case (cmd_type)
        lce_pkg::e_cmd_set_tag:        set_tag_n = 1'b1;
        lce_pkg::e_cmd_set_tag_wakeup: wakeup_n  = 1'b1;
        lce_pkg::e_cmd_data:           data_n    = 1'b1;
        lce_pkg::e_cmd_uc_data:        uc_data_n = 1'b1;
        // reserved codes give no strobe
        default: ;
      endcase
    end
  end

  // one cycle strobes toward the request fsm
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      set_tag_rcv_o <= 1'b0;
      wakeup_rcv_o  <= 1'b0;
      data_rcv_o    <= 1'b0;
      uc_data_rcv_o <= 1'b0;
    end else begin
      set_tag_rcv_o <= set_tag_n;
      wakeup_rcv_o  <= wakeup_n;
      data_rcv_o    <= data_n;
      uc_data_rcv_o <= uc_data_n;
    end
  end

endmodule

/* src/lce_req_fsm.sv */
// miss request fsm: miss capture, request send, resolution wait and coherence ack
`timescale 1ns/10ps

module lce_req_fsm #(
  parameter int  paddr_width_p = 32,
  parameter int  dword_width_p = 64,
  parameter int  lce_assoc_p   = 8,
  localparam int way_width_lp  = $clog2(lce_assoc_p)
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     load_miss_i,
  input  logic                     store_miss_i,
  input  logic                     lr_miss_i,
  input  logic                     uncached_load_req_i,
  input  logic                     uncached_store_req_i,
  input  logic [paddr_width_p-1:0] miss_addr_i,
  input  logic [way_width_lp-1:0]  lru_way_i,
  input  logic [lce_assoc_p-1:0]   dirty_i,
  input  logic [dword_width_p-1:0] store_data_i,
  input  lce_pkg::uc_size_e        size_op_i,
  input  logic                     set_tag_rcv_i,
  input  logic                     wakeup_rcv_i,
  input  logic                     data_rcv_i,
  input  logic                     uc_data_rcv_i,
  input  logic                     credits_full_i,
  input  logic                     lce_req_ready_i,
  input  logic                     lce_resp_yumi_i,
  output logic                     cache_miss_o,
  output logic [paddr_width_p-1:0] miss_addr_o,
  output logic                     lce_req_uncached_store_o,
  output logic                     req_v_o,
  output lce_pkg::req_type_e       req_type_o,
  output logic [paddr_width_p-1:0] req_addr_o,
  output logic [way_width_lp-1:0]  req_lru_way_o,
  output logic                     req_lru_dirty_o,
  output lce_pkg::uc_size_e        req_uc_size_o,
  output logic [dword_width_p-1:0] req_data_o,
  output logic                     resp_v_o
);

  typedef enum logic [2:0] {
    e_ready,
    e_send_cached,
    e_send_uc_load,
    e_sleep,
    e_send_ack
  } state_e;

  state_e                    state_r, state_n;
  logic                      load_not_store_r, load_not_store_n;
  logic [paddr_width_p-1:0]  miss_addr_r, miss_addr_n;
  lce_pkg::uc_size_e         size_op_r, size_op_n;
  logic [way_width_lp-1:0]   lru_way_r, lru_way_n;
  logic                      dirty_r, dirty_n;
  logic                      lru_held_r, lru_held_n;
  logic                      set_tag_r, set_tag_n;
  logic                      data_r, data_n;

  logic                      set_tag_seen;
  logic                      data_seen;
  logic                      uc_store_ok;
  logic [way_width_lp-1:0]   lru_way_cur;
  logic                      dirty_cur;

  // set_tag and data may land in either order
  assign set_tag_seen = set_tag_r | set_tag_rcv_i;
  assign data_seen    = data_r | data_rcv_i;

  assign uc_store_ok = lce_req_ready_i & ~credits_full_i;

  // lru way and dirty bit frozen after the first send cycle
  assign lru_way_cur = lru_held_r ? lru_way_r : lru_way_i;
  assign dirty_cur   = lru_held_r ? dirty_r : dirty_i[lru_way_i];

  assign miss_addr_o = miss_addr_r;

  always_comb begin
    state_n          = state_r;
    load_not_store_n = load_not_store_r;
    miss_addr_n      = miss_addr_r;
    size_op_n        = size_op_r;
    lru_way_n        = lru_way_r;
    dirty_n          = dirty_r;
    lru_held_n       = lru_held_r;
    set_tag_n        = set_tag_r;
    data_n           = data_r;

    cache_miss_o             = 1'b0;
    lce_req_uncached_store_o = 1'b0;
    req_v_o                  = 1'b0;
    req_type_o               = lce_pkg::e_req_rd;
    req_addr_o               = miss_addr_r;
    req_lru_way_o            = '0;
    req_lru_dirty_o          = 1'b0;
    req_uc_size_o            = lce_pkg::e_uc_byte;
    req_data_o               = '0;
    resp_v_o                 = 1'b0;

    case (state_r)
      e_ready: begin
        if (lr_miss_i | load_miss_i | store_miss_i) begin
          // lr goes out as a write so the block arrives exclusive
          load_not_store_n = load_miss_i & ~lr_miss_i;
          miss_addr_n      = miss_addr_i;
          lru_held_n       = 1'b0;
          set_tag_n        = 1'b0;
          data_n           = 1'b0;
          cache_miss_o     = 1'b1;
          state_n          = e_send_cached;
        end else if (uncached_load_req_i) begin
          miss_addr_n  = miss_addr_i;
          size_op_n    = size_op_i;
          set_tag_n    = 1'b0;
          data_n       = 1'b0;
          cache_miss_o = 1'b1;
          state_n      = e_send_uc_load;
        end else if (uncached_store_req_i) begin
          // fire and forget, sent straight from the miss inputs
          req_v_o                  = uc_store_ok;
          req_type_o               = lce_pkg::e_req_uc_wr;
          req_addr_o               = miss_addr_i;
          req_uc_size_o            = size_op_i;
          req_data_o               = store_data_i;
          cache_miss_o             = ~uc_store_ok;
          lce_req_uncached_store_o = uc_store_ok;
        end
      end

      e_send_cached: begin
        lru_held_n      = 1'b1;
        lru_way_n       = lru_way_cur;
        dirty_n         = dirty_cur;
        req_v_o         = ~credits_full_i;
        req_type_o      = load_not_store_r ? lce_pkg::e_req_rd : lce_pkg::e_req_wr;
        req_lru_way_o   = lru_way_cur;
        req_lru_dirty_o = dirty_cur;
        cache_miss_o    = 1'b1;
        if (lce_req_ready_i & ~credits_full_i) begin
          state_n = e_sleep;
        end
      end

      e_send_uc_load: begin
        req_v_o       = ~credits_full_i;
        req_type_o    = lce_pkg::e_req_uc_rd;
        req_uc_size_o = size_op_r;
        cache_miss_o  = 1'b1;
        if (lce_req_ready_i & ~credits_full_i) begin
          state_n = e_sleep;
        end
      end

      e_sleep: begin
        cache_miss_o = 1'b1;
        set_tag_n    = set_tag_seen;
        data_n       = data_seen;
        if (wakeup_rcv_i) begin
          state_n = e_send_ack;
        end else if (uc_data_rcv_i) begin
          // uncached load done, no ack owed
          state_n = e_ready;
        end else if (set_tag_seen & data_seen) begin
          state_n = e_send_ack;
        end
      end

      e_send_ack: begin
        resp_v_o     = 1'b1;
        cache_miss_o = 1'b1;
        if (lce_resp_yumi_i) begin
          state_n = e_ready;
        end
      end

      default: begin
        state_n = e_ready;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= e_ready;
      lru_held_r <= 1'b0;
      set_tag_r  <= 1'b0;
      data_r     <= 1'b0;
    end else begin
      state_r    <= state_n;
      lru_held_r <= lru_held_n;
      set_tag_r  <= set_tag_n;
      data_r     <= data_n;
    end
  end

  // captured miss fields
  always_ff @(posedge clk_i) begin
    load_not_store_r <= load_not_store_n;
    miss_addr_r      <= miss_addr_n;
    size_op_r        <= size_op_n;
    lru_way_r        <= lru_way_n;
    dirty_r          <= dirty_n;
  end

endmodule

/* src/lce_msg_out.sv */
// request and response word packing, destination cce select and request credit counter
`timescale 1ns/10ps

module lce_msg_out #(
  parameter int  paddr_width_p = 32,
  parameter int  dword_width_p = 64,
  parameter int  lce_assoc_p   = 8,
  parameter int  num_cce_p     = 4,
  parameter int  credits_p     = 4,
  localparam int way_width_lp  = $clog2(lce_assoc_p),
  localparam int req_width_lp  = lce_pkg::req_width_f(paddr_width_p, lce_assoc_p, dword_width_p),
  localparam int resp_width_lp = lce_pkg::resp_width_f(paddr_width_p)
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  lce_pkg::lce_id_t         lce_id_i,
  input  logic                     req_v_i,
  input  lce_pkg::req_type_e       req_type_i,
  input  logic [paddr_width_p-1:0] req_addr_i,
  input  logic [way_width_lp-1:0]  req_lru_way_i,
  input  logic                     req_lru_dirty_i,
  input  lce_pkg::uc_size_e        req_uc_size_i,
  input  logic [dword_width_p-1:0] req_data_i,
  input  logic                     resp_v_i,
  input  logic                     lce_req_ready_i,
  input  logic                     credit_return_i,
  output logic [req_width_lp-1:0]  lce_req_o,
  output logic                     lce_req_v_o,
  output logic [resp_width_lp-1:0] lce_resp_o,
  output logic                     lce_resp_v_o,
  output logic                     credits_full_o
);

  // block offset is word offset plus byte offset
  localparam int block_offset_lp  = $clog2(lce_assoc_p) + $clog2(dword_width_p / 8);
  localparam int cce_sel_width_lp = (num_cce_p > 1) ? $clog2(num_cce_p) : 1;
  localparam int credit_width_lp  = $clog2(credits_p + 1);

  lce_pkg::cce_id_t           dst_cce;
  logic                       req_accept;
  logic [credit_width_lp-1:0] credit_count_r;

  // directories interleaved on the bits just above the block offset
  assign dst_cce = (num_cce_p > 1)
    ? lce_pkg::cce_id_t'(req_addr_i[block_offset_lp +: cce_sel_width_lp])
    : '0;

  assign lce_req_o = {
    req_type_i,
    dst_cce,
    lce_id_i,
    req_addr_i,
    req_lru_way_i,
    req_lru_dirty_i,
    req_uc_size_i,
    req_data_i
  };
  assign lce_req_v_o = req_v_i;

  // the only response sent is the coherence ack
  assign lce_resp_o   = {lce_pkg::e_resp_coh_ack, dst_cce, lce_id_i, req_addr_i};
  assign lce_resp_v_o = resp_v_i;

  assign req_accept = req_v_i & lce_req_ready_i;

  // outstanding requests, up on accept and down on credit return
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_count_r <= '0;
    end else if (req_accept & ~credit_return_i) begin
      credit_count_r <= credit_count_r + 1'b1;
    end else if (~req_accept & credit_return_i & (credit_count_r != '0)) begin
      credit_count_r <= credit_count_r - 1'b1;
    end
  end

  assign credits_full_o = (credit_count_r == credit_width_lp'(credits_p));

endmodule

/* src/lce_top.sv */
// lce miss engine top with command decode, request fsm and message output stages
`timescale 1ns/10ps

module lce_top #(
  parameter int  paddr_width_p = 32,
  parameter int  dword_width_p = 64,
  parameter int  lce_assoc_p   = 8,
  parameter int  num_cce_p     = 4,
  parameter int  credits_p     = 4,
  localparam int way_width_lp  = $clog2(lce_assoc_p),
  localparam int cmd_width_lp  = lce_pkg::cmd_width_f(paddr_width_p),
  localparam int req_width_lp  = lce_pkg::req_width_f(paddr_width_p, lce_assoc_p, dword_width_p),
  localparam int resp_width_lp = lce_pkg::resp_width_f(paddr_width_p)
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     load_miss_i,
  input  logic                     store_miss_i,
  input  logic                     lr_miss_i,
  input  logic                     uncached_load_req_i,
  input  logic                     uncached_store_req_i,
  input  logic [paddr_width_p-1:0] miss_addr_i,
  input  logic [way_width_lp-1:0]  lru_way_i,
  input  logic [lce_assoc_p-1:0]   dirty_i,
  input  logic [dword_width_p-1:0] store_data_i,
  input  lce_pkg::uc_size_e        size_op_i,
  input  lce_pkg::lce_id_t         lce_id_i,
  input  logic                     cmd_v_i,
  input  logic [cmd_width_lp-1:0]  cmd_i,
  input  logic                     credit_return_i,
  output logic                     cache_miss_o,
  output logic [paddr_width_p-1:0] miss_addr_o,
  output logic                     lce_req_uncached_store_o,
  output logic [req_width_lp-1:0]  lce_req_o,
  output logic                     lce_req_v_o,
  input  logic                     lce_req_ready_i,
  output logic [resp_width_lp-1:0] lce_resp_o,
  output logic                     lce_resp_v_o,
  input  logic                     lce_resp_yumi_i
);

  logic                     set_tag_rcv;
  logic                     wakeup_rcv;
  logic                     data_rcv;
  logic                     uc_data_rcv;
  logic                     req_v;
  lce_pkg::req_type_e       req_type;
  logic [paddr_width_p-1:0] req_addr;
  logic [way_width_lp-1:0]  req_lru_way;
  logic                     req_lru_dirty;
  lce_pkg::uc_size_e        req_uc_size;
  logic [dword_width_p-1:0] req_data;
  logic                     resp_v;
  logic                     credits_full;

  // decode stage
  lce_cmd_decode #(
    .paddr_width_p(paddr_width_p)
  ) lce_cmd_decode_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .lce_id_i     (lce_id_i),
    .cmd_v_i      (cmd_v_i),
    .cmd_i        (cmd_i),
    .set_tag_rcv_o(set_tag_rcv),
    .wakeup_rcv_o (wakeup_rcv),
    .data_rcv_o   (data_rcv),
    .uc_data_rcv_o(uc_data_rcv)
  );

  // execute stage
  lce_req_fsm #(
    .paddr_width_p(paddr_width_p),
    .dword_width_p(dword_width_p),
    .lce_assoc_p  (lce_assoc_p)
  ) lce_req_fsm_inst (
    .clk_i                   (clk_i),
    .reset_i                 (reset_i),
    .load_miss_i             (load_miss_i),
    .store_miss_i            (store_miss_i),
    .lr_miss_i               (lr_miss_i),
    .uncached_load_req_i     (uncached_load_req_i),
    .uncached_store_req_i    (uncached_store_req_i),
    .miss_addr_i             (miss_addr_i),
    .lru_way_i               (lru_way_i),
    .dirty_i                 (dirty_i),
    .store_data_i            (store_data_i),
    .size_op_i               (size_op_i),
    .set_tag_rcv_i           (set_tag_rcv),
    .wakeup_rcv_i            (wakeup_rcv),
    .data_rcv_i              (data_rcv),
    .uc_data_rcv_i           (uc_data_rcv),
    .credits_full_i          (credits_full),
    .lce_req_ready_i         (lce_req_ready_i),
    .lce_resp_yumi_i         (lce_resp_yumi_i),
    .cache_miss_o            (cache_miss_o),
    .miss_addr_o             (miss_addr_o),
    .lce_req_uncached_store_o(lce_req_uncached_store_o),
    .req_v_o                 (req_v),
    .req_type_o              (req_type),
    .req_addr_o              (req_addr),
    .req_lru_way_o           (req_lru_way),
    .req_lru_dirty_o         (req_lru_dirty),
    .req_uc_size_o           (req_uc_size),
    .req_data_o              (req_data),
    .resp_v_o                (resp_v)
  );

  // result stage
  lce_msg_out #(
    .paddr_width_p(paddr_width_p),
    .dword_width_p(dword_width_p),
    .lce_assoc_p  (lce_assoc_p),
    .num_cce_p    (num_cce_p),
    .credits_p    (credits_p)
  ) lce_msg_out_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .lce_id_i       (lce_id_i),
    .req_v_i        (req_v),
    .req_type_i     (req_type),
    .req_addr_i     (req_addr),
    .req_lru_way_i  (req_lru_way),
    .req_lru_dirty_i(req_lru_dirty),
    .req_uc_size_i  (req_uc_size),
    .req_data_i     (req_data),
    .resp_v_i       (resp_v),
    .lce_req_ready_i(lce_req_ready_i),
    .credit_return_i(credit_return_i),
    .lce_req_o      (lce_req_o),
    .lce_req_v_o    (lce_req_v_o),
    .lce_resp_o     (lce_resp_o),
    .lce_resp_v_o   (lce_resp_v_o),
    .credits_full_o (credits_full)
  );

endmodule

/* include/lce_tb_vectors.svh */
// stimulus and expected value table for the lce miss engine testbench loop
`ifndef LCE_TB_VECTORS_SVH
`define LCE_TB_VECTORS_SVH

// op: 0 load, 1 store, 2 lr, 3 lr with load, 4 uncached load,
//     5 uncached store, 6 uncached store while credits are full
// res: 0 set_tag then data, 1 data then set_tag, 2 wakeup, 3 uc_data, 4 none
// rstall and ystall are the base ready and yumi stall cycles
localparam int num_rows_c = 13;

localparam int row_op_c [num_rows_c] = '{
  0, 1, 2, 3, 0, 4, 5, 5, 5, 5, 6, 1, 4
};

localparam int row_res_c [num_rows_c] = '{
  0, 1, 2, 0, 2, 3, 4, 4, 4, 4, 4, 0, 3
};

localparam int row_rstall_c [num_rows_c] = '{
  0, 2, 1, 3, 0, 2, 0, 2, 0, 1, 0, 1, 0
};

localparam int row_ystall_c [num_rows_c] = '{
  0, 1, 0, 2, 3, 0, 0, 0, 0, 0, 0, 2, 0
};

// expected request type
localparam int row_type_c [num_rows_c] = '{
  lce_pkg::e_req_rd,    lce_pkg::e_req_wr,    lce_pkg::e_req_wr,    lce_pkg::e_req_wr,
  lce_pkg::e_req_rd,    lce_pkg::e_req_uc_rd, lce_pkg::e_req_uc_wr, lce_pkg::e_req_uc_wr,
  lce_pkg::e_req_uc_wr, lce_pkg::e_req_uc_wr, lce_pkg::e_req_uc_wr, lce_pkg::e_req_wr,
  lce_pkg::e_req_uc_rd
};

// 1 when a coherence ack is owed
localparam int row_ack_c [num_rows_c] = '{
  1, 1, 1, 1, 1, 0, 0, 0, 0, 0, 0, 1, 0
};

`endif

/* tests/lce_tb.sv */
// testbench for lce_top with cce model, table driven rows, check task and watchdog
`timescale 1ns/10ps

module lce_tb;

  localparam int paddr_c   = 32;
  localparam int dword_c   = 64;
  localparam int assoc_c   = 8;
  localparam int credits_c = 4;
  localparam int cmd_w_c   = lce_pkg::cmd_width_f(paddr_c);
  localparam int req_w_c   = lce_pkg::req_width_f(paddr_c, assoc_c, dword_c);
  localparam int resp_w_c  = lce_pkg::resp_width_f(paddr_c);
  localparam lce_pkg::lce_id_t own_id_c   = 4'h5;
  localparam lce_pkg::lce_id_t other_id_c = 4'h4;

  logic clk_i;
  logic reset_i;
  logic load_miss_i;
  logic store_miss_i;
  logic lr_miss_i;
  logic uncached_load_req_i;
  logic uncached_store_req_i;
  logic cmd_v_i;
  logic credit_return_i;
  logic [paddr_c-1:0] miss_addr_i;
  logic [paddr_c-1:0] miss_addr_o;
  logic [2:0] lru_way_i;
  logic [assoc_c-1:0] dirty_i;
  logic [dword_c-1:0] store_data_i;
  lce_pkg::uc_size_e size_op_i;
  lce_pkg::lce_id_t lce_id_i;
  logic [cmd_w_c-1:0] cmd_i;
  logic cache_miss_o;
  logic lce_req_uncached_store_o;
  logic lce_req_v_o;
  logic lce_req_ready_i;
  logic [req_w_c-1:0] lce_req_o;
  logic [resp_w_c-1:0] lce_resp_o;
  logic lce_resp_v_o;
  logic lce_resp_yumi_i;

  int    req_count;
  int    resp_count;
  int    outstanding;
  string test_name;
  logic [paddr_c-1:0] cur_addr;

  `include "lce_tb_vectors.svh"

  lce_top #(
    .paddr_width_p(paddr_c),
    .dword_width_p(dword_c),
    .lce_assoc_p  (assoc_c),
    .num_cce_p    (4),
    .credits_p    (credits_c)
  ) lce_top_inst (
    .clk_i(clk_i), .reset_i(reset_i),
    .load_miss_i(load_miss_i), .store_miss_i(store_miss_i), .lr_miss_i(lr_miss_i),
    .uncached_load_req_i(uncached_load_req_i), .uncached_store_req_i(uncached_store_req_i),
    .miss_addr_i(miss_addr_i), .lru_way_i(lru_way_i), .dirty_i(dirty_i),
    .store_data_i(store_data_i), .size_op_i(size_op_i), .lce_id_i(lce_id_i),
    .cmd_v_i(cmd_v_i), .cmd_i(cmd_i), .credit_return_i(credit_return_i),
    .cache_miss_o(cache_miss_o), .miss_addr_o(miss_addr_o),
    .lce_req_uncached_store_o(lce_req_uncached_store_o),
    .lce_req_o(lce_req_o), .lce_req_v_o(lce_req_v_o), .lce_req_ready_i(lce_req_ready_i),
    .lce_resp_o(lce_resp_o), .lce_resp_v_o(lce_resp_v_o), .lce_resp_yumi_i(lce_resp_yumi_i)
  );

  always #50 clk_i = ~clk_i;

  // transfers seen on both channels
  always @(posedge clk_i) begin
    if (!reset_i && lce_req_v_o && lce_req_ready_i) req_count++;
    if (!reset_i && lce_resp_v_o && lce_resp_yumi_i) resp_count++;
  end

  initial begin
    #(num_rows_c * 200 * 100);
    $display("watchdog expired, the run did not finish in time");
    $display("Test FAILED");
    $fatal(1, "timeout");
  end

  task automatic check_value(input string what, input logic [127:0] exp_val,
                             input logic [127:0] act_val);
    if (exp_val !== act_val) begin
      $display("Fail %s %s expected %h actual %h", test_name, what, exp_val, act_val);
      $display("Test FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic abort_with_message(input string msg);
    $display("%s: %s", test_name, msg);
    $display("Test FAILED");
    $fatal(1, "failure");
  endtask

  // word layout {type, dst cce, src lce, addr, way, dirty, size, data}
  function automatic logic [127:0] exp_req_word(input logic [2:0] typ, input logic [31:0] addr,
      input logic [2:0] way, input logic dirty, input logic [1:0] size, input logic [63:0] data);
    logic [3:0] cce;
    // four cces interleaved above a 64 byte block
    cce = {2'b00, addr[7:6]};
    return 128'({typ, cce, own_id_c, addr, way, dirty, size, data});
  endfunction

  function automatic logic [127:0] exp_resp_word(input logic [31:0] addr);
    logic [3:0] cce;
    cce = {2'b00, addr[7:6]};
    return 128'({2'd2, cce, own_id_c, addr});
  endfunction

  task automatic send_cmd(input lce_pkg::cmd_type_e typ, input lce_pkg::lce_id_t dst);
    @(posedge clk_i);
    cmd_v_i <= 1'b1;
    cmd_i   <= {typ, dst, cur_addr};
    @(posedge clk_i);
    cmd_v_i <= 1'b0;
  endtask

  // request held under ready stalls while way and dirty inputs keep changing
  task automatic send_with_stall(input logic [127:0] exp_word, input int stalls);
    for (int s = 0; s < stalls; s++) begin
      @(negedge clk_i);
      check_value("req valid stall", 1, 128'(lce_req_v_o));
      check_value("req word stall", exp_word, 128'(lce_req_o));
      @(posedge clk_i);
      lru_way_i <= 3'($urandom);
      dirty_i   <= 8'($urandom);
    end
    lce_req_ready_i <= 1'b1;
    @(negedge clk_i);
    check_value("req valid", 1, 128'(lce_req_v_o));
    check_value("req word", exp_word, 128'(lce_req_o));
    @(posedge clk_i);
    lce_req_ready_i <= 1'b0;
  endtask

  task automatic wait_resp_valid();
    int n;
    n = 0;
    while (lce_resp_v_o !== 1'b1) begin
      @(negedge clk_i);
      n++;
      if (n > 20) abort_with_message("no coherence ack after the resolution");
    end
  endtask

  task automatic wait_miss_low();
    int n;
    n = 0;
    while (cache_miss_o !== 1'b0) begin
      @(negedge clk_i);
      n++;
      if (n > 20) abort_with_message("cache_miss_o never fell after uc_data");
    end
  endtask

  task automatic return_credit();
    @(posedge clk_i);
    credit_return_i <= 1'b1;
    @(posedge clk_i);
    credit_return_i <= 1'b0;
    outstanding--;
  endtask

  // foreign command first and then the real resolution
  task automatic resolve(input int res);
    send_cmd(lce_pkg::e_cmd_set_tag_wakeup, other_id_c);
    repeat (2) @(negedge clk_i);
    check_value("foreign cmd resp valid", 0, 128'(lce_resp_v_o));
    check_value("foreign cmd miss", 1, 128'(cache_miss_o));
    if (res == 2) begin
      send_cmd(lce_pkg::e_cmd_set_tag_wakeup, own_id_c);
    end else if (res == 3) begin
      send_cmd(lce_pkg::e_cmd_uc_data, own_id_c);
    end else begin
      send_cmd(res == 0 ? lce_pkg::e_cmd_set_tag : lce_pkg::e_cmd_data, own_id_c);
      repeat (2) @(negedge clk_i);
      check_value("half resolved resp valid", 0, 128'(lce_resp_v_o));
      send_cmd(res == 0 ? lce_pkg::e_cmd_data : lce_pkg::e_cmd_set_tag, own_id_c);
    end
    @(negedge clk_i);
  endtask

  task automatic run_ack(input int ystall);
    wait_resp_valid();
    check_value("resp word", exp_resp_word(cur_addr), 128'(lce_resp_o));
    for (int s = 0; s < ystall; s++) begin
      @(negedge clk_i);
      check_value("resp valid stall", 1, 128'(lce_resp_v_o));
      check_value("miss during ack", 1, 128'(cache_miss_o));
    end
    @(posedge clk_i);
    lce_resp_yumi_i <= 1'b1;
    @(negedge clk_i);
    check_value("miss at yumi", 1, 128'(cache_miss_o));
    @(posedge clk_i);
    lce_resp_yumi_i <= 1'b0;
    @(negedge clk_i);
    check_value("miss after yumi", 0, 128'(cache_miss_o));
  endtask

  task automatic run_row(input int i);
    int op;
    int rstall;
    int req_base;
    int resp_base;
    logic [2:0] way;
    logic [7:0] dvec;
    logic [1:0] size;
    logic [63:0] data;
    op        = row_op_c[i];
    rstall    = row_rstall_c[i] + int'($urandom % 2);
    req_base  = req_count;
    resp_base = resp_count;
    cur_addr  = $urandom;
    size      = 2'($urandom);
    data      = {$urandom, $urandom};
    test_name = $sformatf("row %0d op %0d", i, op);
    @(posedge clk_i);
    miss_addr_i  <= cur_addr;
    size_op_i    <= lce_pkg::uc_size_e'(size);
    store_data_i <= data;
    if (op <= 4) begin
      load_miss_i         <= (op == 0 || op == 3);
      store_miss_i        <= (op == 1);
      lr_miss_i           <= (op == 2 || op == 3);
      uncached_load_req_i <= (op == 4);
      @(negedge clk_i);
      check_value("miss raised", 1, 128'(cache_miss_o));
      check_value("req valid early", 0, 128'(lce_req_v_o));
      @(posedge clk_i);
      {load_miss_i, store_miss_i, lr_miss_i, uncached_load_req_i} <= 4'b0;
      way  = 3'($urandom);
      dvec = 8'($urandom);
      lru_way_i <= way;
      dirty_i   <= dvec;
      if (op == 4) begin
        send_with_stall(exp_req_word(3'(row_type_c[i]), cur_addr, 3'd0, 1'b0, size, 64'd0),
                        rstall);
      end else begin
        send_with_stall(exp_req_word(3'(row_type_c[i]), cur_addr, way, dvec[way], 2'd0,
                                     64'd0), rstall);
      end
      outstanding++;
      @(negedge clk_i);
      check_value("request count", 1, 128'(req_count - req_base));
      check_value("miss addr", 128'(cur_addr), 128'(miss_addr_o));
      resolve(row_res_c[i]);
      if (row_ack_c[i] == 1) run_ack(row_ystall_c[i]);
      else wait_miss_low();
      return_credit();
    end else begin
      uncached_store_req_i <= 1'b1;
      lce_req_ready_i      <= (op == 6 || rstall == 0);
      if (op == 6) begin
        @(negedge clk_i);
        check_value("full store valid", 0, 128'(lce_req_v_o));
        check_value("full store pulse", 0, 128'(lce_req_uncached_store_o));
        check_value("full store miss", 1, 128'(cache_miss_o));
      end else begin
        for (int s = 0; s < rstall; s++) begin
          @(negedge clk_i);
          check_value("stalled store valid", 0, 128'(lce_req_v_o));
          check_value("stalled store miss", 1, 128'(cache_miss_o));
          @(posedge clk_i);
          if (s == rstall - 1) lce_req_ready_i <= 1'b1;
        end
        @(negedge clk_i);
        check_value("store pulse", 1, 128'(lce_req_uncached_store_o));
        check_value("store miss", 0, 128'(cache_miss_o));
        check_value("store word", exp_req_word(3'(row_type_c[i]), cur_addr, 3'd0, 1'b0, size,
                                               data), 128'(lce_req_o));
        outstanding++;
      end
      @(posedge clk_i);
      uncached_store_req_i <= 1'b0;
      lce_req_ready_i      <= 1'b0;
      @(negedge clk_i);
      check_value("request count", op == 6 ? 0 : 1, 128'(req_count - req_base));
      if (op == 6) begin
        while (outstanding > 0) return_credit();
      end
    end
    check_value("ack count", row_ack_c[i], 128'(resp_count - resp_base));
  endtask

  initial begin
    void'($urandom(32'hdd64_9cba));
    clk_i = 1'b0;
    reset_i = 1'b1;
    {load_miss_i, store_miss_i, lr_miss_i} = 3'b0;
    {uncached_load_req_i, uncached_store_req_i} = 2'b0;
    miss_addr_i = '0;
    lru_way_i = '0;
    dirty_i = '0;
    store_data_i = '0;
    size_op_i = lce_pkg::e_uc_byte;
    lce_id_i = own_id_c;
    cmd_v_i = 1'b0;
    cmd_i = '0;
    credit_return_i = 1'b0;
    lce_req_ready_i = 1'b0;
    lce_resp_yumi_i = 1'b0;
    req_count = 0;
    resp_count = 0;
    outstanding = 0;
    test_name = "reset";
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_value("miss after reset", 0, 128'(cache_miss_o));
    check_value("req valid after reset", 0, 128'(lce_req_v_o));
    check_value("resp valid after reset", 0, 128'(lce_resp_v_o));
    check_value("store pulse after reset", 0, 128'(lce_req_uncached_store_o));
    for (int i = 0; i < num_rows_c; i++) begin
      run_row(i);
    end
    $display("Test OK");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
src/lce_pkg.sv
src/lce_cmd_decode.sv
src/lce_req_fsm.sv
src/lce_msg_out.sv
src/lce_top.sv
tests/lce_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the lce testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  -f filelist.f \
  --top-module lce_tb \
  -o lce_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/lce_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
